// File: opll_eg_top.f
+incdir+.
eg_slot_pkg.sv
eg_state_pkg.sv
eg_rate_timer.sv
eg_envelope_core.sv
eg_key_scale.sv
eg_output_mix.sv
opll_eg_top.sv
tb_opll_eg.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --assert --Wno-fatal -f opll_eg_top.f --top-module tb_opll_eg -o sim_eg
	@out=$$(./obj_dir/sim_eg); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: tb_opll_eg.sv
module tb_opll_eg;
timeunit 1ns;
timeprecision 1ps;

logic                          emuclk;
logic                          i_RST_n;
logic                          i_frame_start;
eg_slot_pkg::eg_pitch_t        i_pitch;
eg_slot_pkg::eg_rate_params_t  i_rate;
eg_slot_pkg::eg_level_params_t i_level;
logic [3:0]                    i_amval;
eg_state_pkg::eg_level_t       o_op_attnlv;
logic                          o_op_attnlv_max;
logic                          o_pg_phase_rst;

// Per-slot register contents
eg_slot_pkg::eg_pitch_t        pitch_cfg [18];
eg_slot_pkg::eg_rate_params_t  rate_cfg [18];
eg_slot_pkg::eg_level_params_t level_cfg [18];
logic [3:0]                    amval_cfg [18];

int ks_table [16] = '{0, 32, 40, 45, 48, 51, 53, 55, 56, 58, 59, 60, 61, 62, 63, 64};

// Observed outputs per slot and the key-scale sum expected for each
int obs_lvl [18];
int obs_max [18];
int obs_ks [18];
bit rst_seen [18];

int cur_slot, d1_slot, d2_slot, ks_d1, ks_d2, pipe_fill;
int checks, errors, tests_run, tests_failed, test_errs;

opll_eg_top dut (.*);

initial begin
    emuclk = 1'b0;
    forever #20 emuclk = ~emuclk;
end

// Watchdog for the whole run
initial begin
    #50ms;
    $display("Simulation time limit reached before the tests finished");
    $display("Checks failed");
    $finish;
end

////////////////////////////////////////
// Reference model

// Key-scale attenuation, TL and AM from the register fields
function automatic int model_ks(eg_slot_pkg::eg_pitch_t p, eg_slot_pkg::eg_level_params_t l,
                                logic [3:0] amv);
    int base;
    int hi;
    int ks;
    int sum;
    base = ks_table[p.fnum[8:5]];
    hi   = base / 8 + int'(p.block);
    ks   = (hi >= 8 || base == 64) ? (hi % 8) * 8 + base % 8 : 0;
    case (l.ksl)
        2'd0: sum = 0;
        2'd1: sum = ks / 2;
        2'd2: sum = ks;
        default: sum = ks * 2;
    endcase
    sum = sum + 2 * int'(l.tl) + (l.am ? int'(amv) : 0);
    return sum;
endfunction

function automatic int model_out(int env, int ks);
    return (env + ks > 127) ? 127 : env + ks;
endfunction

////////////////////////////////////////
// Slot sequencing
task automatic step_cycle();
    @(negedge emuclk);
    if (pipe_fill >= 2) begin
        obs_lvl[d2_slot] = int'(o_op_attnlv);
        obs_max[d2_slot] = int'(o_op_attnlv_max);
        obs_ks[d2_slot]  = ks_d2;
    end
    if (pipe_fill >= 1 && o_pg_phase_rst) begin
        rst_seen[d1_slot] = 1'b1;
    end
    d2_slot = d1_slot;
    ks_d2   = ks_d1;
    d1_slot = cur_slot;
    ks_d1   = model_ks(pitch_cfg[cur_slot], level_cfg[cur_slot], amval_cfg[cur_slot]);
    i_frame_start = (cur_slot == 0);
    i_pitch = pitch_cfg[cur_slot];
    i_rate  = rate_cfg[cur_slot];
    i_level = level_cfg[cur_slot];
    i_amval = amval_cfg[cur_slot];
    if (pipe_fill < 2) pipe_fill++;
    cur_slot = (cur_slot == 17) ? 0 : cur_slot + 1;
endtask

task automatic run_frame();
    for (int i = 0; i < 18; i++) begin
        step_cycle();
    end
endtask

task automatic check_eq(string name, int slot, int got, int exp);
    checks++;
    if (got != exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s slot %0d got %0d expected %0d",
                 $time, name, slot, got, exp);
    end
endtask

task automatic report_fault(string msg);
    errors++;
    $display("At %0t: %s", $time, msg);
endtask

task automatic begin_test();
    test_errs = errors;
endtask

task automatic end_test(string name);
    tests_run++;
    if (errors != test_errs) begin
        tests_failed++;
        $display("Test %0d %s: FAIL (%0d errors)", tests_run, name, errors - test_errs);
    end else begin
        $display("Test %0d %s: PASS", tests_run, name);
    end
endtask

// Random pitch and level terms for one slot
task automatic randomize_scale(int s);
    pitch_cfg[s].fnum  = 9'($urandom);
    pitch_cfg[s].block = 3'($urandom);
    level_cfg[s].tl    = 6'($urandom);
    level_cfg[s].ksl   = 2'($urandom);
    level_cfg[s].am    = 1'($urandom);
    amval_cfg[s]       = 4'($urandom);
endtask

task automatic clear_scale(int s);
    pitch_cfg[s] = '0;
    level_cfg[s] = '0;
    amval_cfg[s] = '0;
endtask

////////////////////////////////////////
// Test sequence
initial begin
    int t;
    int u;
    int v;
    int prev;
    int held;
    int sl;
    bit done;
    int snap [18];

    void'($urandom(32'h696a4175));
    i_RST_n = 1'b0;
    i_frame_start = 1'b0;
    i_pitch = '0;
    i_rate  = '0;
    i_level = '0;
    i_amval = '0;
    cur_slot = 0;
    d1_slot = 0;
    d2_slot = 0;
    ks_d1 = 0;
    ks_d2 = 0;
    pipe_fill = 0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int s = 0; s < 18; s++) begin
        pitch_cfg[s].fnum  = 9'($urandom);
        pitch_cfg[s].block = 3'($urandom);
        rate_cfg[s]        = '0;
        rate_cfg[s].ksr    = 1'($urandom);
        rate_cfg[s].rr     = 4'($urandom);
        level_cfg[s]       = '0;
        amval_cfg[s]       = 4'($urandom);
        rst_seen[s]        = 1'b0;
    end

    for (int i = 0; i < 18; i++) begin   // 16 reset cycles plus 2 to fill storage
        step_cycle();
    end
    i_RST_n = 1'b1;
    cur_slot = 0;
    pipe_fill = 0;

    // Idle after reset
    begin_test();
    run_frame();
    run_frame();
    for (int s = 0; s < 18; s++) begin
        check_eq("o_op_attnlv", s, obs_lvl[s], 127);
        check_eq("o_op_attnlv_max", s, obs_max[s], 1);
        check_eq("o_pg_phase_rst", s, int'(rst_seen[s]), 0);
    end
    end_test("idle after reset");

    t = int'($urandom % 18);
    u = (t + 1 + int'($urandom % 17)) % 18;
    v = t;
    while (v == t || v == u) v = int'($urandom % 18);

    // Instant attack then key scale through the model
    begin_test();
    rate_cfg[t].kon  = 1'b1;
    rate_cfg[t].ar   = 4'd15;
    rate_cfg[t].dr   = 4'd0;
    rate_cfg[t].sl   = 4'd0;
    rate_cfg[t].etyp = 1'b1;
    run_frame();
    run_frame();
    if (!rst_seen[t]) report_fault("no phase-reset pulse after key-on with AR 15");
    for (int f = 0; f < 12; f++) begin
        randomize_scale(t);
        run_frame();
        run_frame();
        check_eq("o_op_attnlv", t, obs_lvl[t], model_out(0, obs_ks[t]));
    end
    end_test("instant attack and key scale");

    // Overflow saturates
    begin_test();
    for (int f = 0; f < 8; f++) begin
        pitch_cfg[t].fnum  = {1'b1, 8'($urandom)};
        pitch_cfg[t].block = 3'd7;
        level_cfg[t].tl    = 6'(40 + $urandom % 24);
        level_cfg[t].ksl   = 2'd3;
        level_cfg[t].am    = 1'($urandom);
        run_frame();
        run_frame();
        check_eq("o_op_attnlv", t, obs_lvl[t], 127);
        check_eq("o_op_attnlv_max", t, obs_max[t], 0);   // Envelope still at 0
    end
    end_test("saturation");

    // Attack at a moderate rate
    begin_test();
    clear_scale(u);
    rate_cfg[u] = '0;
    rate_cfg[u].kon  = 1'b1;
    rate_cfg[u].etyp = 1'b1;
    rate_cfg[u].ar   = 4'(9 + $urandom % 6);
    prev = 127;
    done = 1'b0;
    for (int f = 0; f < 30000 && !done; f++) begin
        run_frame();
        if (obs_lvl[u] > prev) begin
            report_fault($sformatf("level rose from %0d to %0d during attack", prev, obs_lvl[u]));
        end
        prev = obs_lvl[u];
        if (prev == 0) done = 1'b1;
    end
    if (!done) report_fault("attack did not reach level 0 before the timeout");
    end_test("attack");

    // Decay to SL then sustain
    begin_test();
    clear_scale(v);
    sl = 1 + int'($urandom % 14);
    rate_cfg[v] = '0;
    rate_cfg[v].kon  = 1'b1;
    rate_cfg[v].etyp = 1'b1;
    rate_cfg[v].ar   = 4'd15;
    rate_cfg[v].dr   = 4'd15;
    rate_cfg[v].sl   = 4'(sl);
    run_frame();
    run_frame();
    prev = obs_lvl[v];
    done = 1'b0;
    for (int f = 0; f < 200 && !done; f++) begin
        run_frame();
        if (obs_lvl[v] < prev) report_fault("level fell during decay");
        prev = obs_lvl[v];
        if (prev / 8 == sl) done = 1'b1;
    end
    if (!done) report_fault("decay did not reach the sustain level before the timeout");
    run_frame();
    held = obs_lvl[v];
    for (int f = 0; f < 8; f++) begin
        run_frame();
        check_eq("o_op_attnlv", v, obs_lvl[v], held);
        check_eq("o_op_attnlv[6:3]", v, obs_lvl[v] / 8, sl);
    end
    end_test("decay and sustain");

    // Release back to silence
    begin_test();
    clear_scale(t);
    run_frame();
    run_frame();
    for (int s = 0; s < 18; s++) snap[s] = obs_lvl[s];
    rate_cfg[t].kon = 1'b0;
    rate_cfg[t].rr  = 4'd15;
    rate_cfg[t].ksr = 1'b0;
    done = 1'b0;
    for (int f = 0; f < 200 && !done; f++) begin
        run_frame();
        for (int s = 0; s < 18; s++) begin
            if (s != t) check_eq("o_op_attnlv", s, obs_lvl[s], snap[s]);
        end
        if (obs_lvl[t] == 127 && obs_max[t] == 1) done = 1'b1;
    end
    if (!done) report_fault("release did not reach level 127 before the timeout");
    end_test("release");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// File: opll_eg_top.sv
module opll_eg_top (
    input  logic                           emuclk,
    input  logic                           i_RST_n,
    input  logic                           i_frame_start,
    input  eg_slot_pkg::eg_pitch_t         i_pitch,
    input  eg_slot_pkg::eg_rate_params_t   i_rate,
    input  eg_slot_pkg::eg_level_params_t  i_level,
    input  logic [3:0]                     i_amval,
    output eg_state_pkg::eg_level_t        o_op_attnlv,
    output logic                           o_op_attnlv_max,
    output logic                           o_pg_phase_rst
);

eg_state_pkg::eg_tick_t  tick;
eg_state_pkg::eg_level_t env_level;
logic [7:0]              ks_sum;

////////////////////////////////////////
// Envelope path
eg_rate_timer u_rate_timer (
    .emuclk        (emuclk),
    .i_RST_n       (i_RST_n),
    .i_frame_start (i_frame_start),
    .o_tick        (tick)
);

eg_envelope_core u_envelope_core (
    .emuclk         (emuclk),
    .i_RST_n        (i_RST_n),
    .i_rate         (i_rate),
    .i_pitch        (i_pitch),
    .i_tick         (tick),
    .o_env_level    (env_level),
    .o_pg_phase_rst (o_pg_phase_rst)
);

////////////////////////////////////////
// Key-scale path and final mix
eg_key_scale u_key_scale (
    .emuclk   (emuclk),
    .i_pitch  (i_pitch),
    .i_level  (i_level),
    .i_amval  (i_amval),
    .o_ks_sum (ks_sum)
);

eg_output_mix u_output_mix (
    .emuclk          (emuclk),
    .i_env_level     (env_level),
    .i_ks_sum        (ks_sum),
    .o_op_attnlv     (o_op_attnlv),
    .o_op_attnlv_max (o_op_attnlv_max)
);

endmodule

// File: eg_output_mix.sv
`include "eg_params.svh"

module eg_output_mix (
    input  logic                    emuclk,
    input  eg_state_pkg::eg_level_t i_env_level,
    input  logic [7:0]              i_ks_sum,
    output eg_state_pkg::eg_level_t o_op_attnlv,
    output logic                    o_op_attnlv_max
);

localparam eg_state_pkg::eg_level_t level_max = `EG_LEVEL_MAX;

logic [7:0]              mix_sum;
logic                    mix_ovfl;
eg_state_pkg::eg_level_t mix_sat;

assign mix_sum  = {1'b0, i_env_level} + {1'b0, i_ks_sum[6:0]};
assign mix_ovfl = i_ks_sum[7] | mix_sum[7];             // Carry from either stage
assign mix_sat  = mix_ovfl ? level_max : mix_sum[6:0];

always_ff @(posedge emuclk) begin
    o_op_attnlv     <= mix_sat;
    o_op_attnlv_max <= i_env_level == level_max;   // Envelope alone, key scale ignored
end

endmodule

// File: eg_key_scale.sv
module eg_key_scale (
    input  logic                           emuclk,
    input  eg_slot_pkg::eg_pitch_t         i_pitch,
    input  eg_slot_pkg::eg_level_params_t  i_level,
    input  logic [3:0]                     i_amval,
    output logic [7:0]                     o_ks_sum
);

logic [6:0] ks_base;
logic [3:0] ks_hi;
logic [5:0] ks_val;
logic [6:0] ks_shifted;
logic [8:0] ks_total;

// Base attenuation from the top F-number bits
always_comb begin
    case (i_pitch.fnum[8:5])
        4'h0: ks_base = 7'd0;
        4'h1: ks_base = 7'd32;
        4'h2: ks_base = 7'd40;
        4'h3: ks_base = 7'd45;
        4'h4: ks_base = 7'd48;
        4'h5: ks_base = 7'd51;
        4'h6: ks_base = 7'd53;
        4'h7: ks_base = 7'd55;
        4'h8: ks_base = 7'd56;
        4'h9: ks_base = 7'd58;
        4'hA: ks_base = 7'd59;
        4'hB: ks_base = 7'd60;
        4'hC: ks_base = 7'd61;
        4'hD: ks_base = 7'd62;
        4'hE: ks_base = 7'd63;
        default: ks_base = 7'd64;
    endcase
end

assign ks_hi  = {1'b0, ks_base[5:3]} + {1'b0, i_pitch.block};
assign ks_val = (ks_hi[3] | ks_base[6]) ? {ks_hi[2:0], ks_base[2:0]} : 6'd0;  // Low octaves drop out

always_comb begin
    case (i_level.ksl)
        2'd0: ks_shifted = 7'd0;
        2'd1: ks_shifted = {2'b00, ks_val[5:1]};
        2'd2: ks_shifted = {1'b0, ks_val};
        default: ks_shifted = {ks_val, 1'b0};
    endcase
end

assign ks_total = {2'b00, ks_shifted} + {2'b00, i_level.tl, 1'b0}
                + {5'd0, i_level.am ? i_amval : 4'd0};

// Bit 7 holds any carry past 7 bits
always_ff @(posedge emuclk) begin
    o_ks_sum <= {|ks_total[8:7], ks_total[6:0]};
end

endmodule

// File: eg_envelope_core.sv
`include "eg_params.svh"

module eg_envelope_core (
    input  logic                          emuclk,
    input  logic                          i_RST_n,
    input  eg_slot_pkg::eg_rate_params_t  i_rate,
    input  eg_slot_pkg::eg_pitch_t        i_pitch,
    input  eg_state_pkg::eg_tick_t        i_tick,
    output eg_state_pkg::eg_level_t       o_env_level,
    output logic                          o_pg_phase_rst
);

localparam int sr_len = `EG_SLOTS - 1;   // Output register is the head of the storage
localparam int lvl_w  = `EG_LEVEL_W;
localparam logic [`EG_RATE_W-1:0] damp_rate    = `EG_DAMP_RATE;
localparam logic [`EG_RATE_W-1:0] car_off_rate = `EG_CARRIER_OFF_RATE;
localparam logic [`EG_RATE_W-1:0] sus_rate     = `EG_SUSTAIN_RATE;
localparam eg_state_pkg::eg_level_t level_max  = `EG_LEVEL_MAX;

eg_state_pkg::eg_level_t level_sr [sr_len];
eg_state_pkg::eg_phase_e phase_sr [sr_len];
eg_state_pkg::eg_phase_e phase_q;
eg_state_pkg::eg_level_t cur_level, cur_base, next_level;
eg_state_pkg::eg_phase_e cur_phase, masked_phase, next_phase;
eg_state_pkg::eg_level_t inv_level, delta_0, delta_1, delta_2, delta_3, delta;

logic                  quiet, level_min, decay_end, start_attack;
logic                  damp, carrier_off;
logic [`EG_RATE_W-1:0] rate_sel, rate_sat, rate_final;
logic [4:0]            rate_scaled;
logic [3:0]            ksr_factor;
logic                  rate_zero, rate_12, rate_13, rate_14, rate_15;
logic                  intensity, slow_atten, attn_act, dec_level, pre_3;
logic [3:0]            sel;

////////////////////////////////////////
// Stored state of the current slot
assign cur_level    = level_sr[sr_len-1];
assign cur_phase    = phase_sr[sr_len-1];
assign quiet        = &cur_level[lvl_w-1 -: `EG_QUIET_BITS];
assign level_min    = cur_level == '0;
assign decay_end    = cur_level[lvl_w-1 -: `EG_RATE_W] == i_rate.sl;
assign start_attack = (cur_phase == eg_state_pkg::ph_release) & quiet & i_rate.kon;
assign masked_phase = start_attack ? eg_state_pkg::ph_attack : cur_phase;

////////////////////////////////////////
// Rate selection
assign damp        = i_rate.kon & (cur_phase == eg_state_pkg::ph_release) & ~quiet;
assign carrier_off = ~i_rate.kon & ~i_rate.susen & i_rate.carrier & ~i_rate.etyp;

always_comb begin
    rate_sel = i_rate.rr;
    if (damp) begin
        rate_sel = damp_rate;      // Fade out the old note first
    end else if (carrier_off) begin
        rate_sel = car_off_rate;
    end else begin
        case (masked_phase)
            eg_state_pkg::ph_attack:  rate_sel = i_rate.ar;
            eg_state_pkg::ph_decay:   rate_sel = i_rate.dr;
            eg_state_pkg::ph_sustain: rate_sel = i_rate.etyp ? '0 : i_rate.rr;
            default:                  rate_sel = i_rate.susen ? sus_rate : i_rate.rr;
        endcase
    end
end

// Key-scale rate factor and saturation
assign ksr_factor  = i_rate.ksr ? {i_pitch.block, i_pitch.fnum[8]}
                                : {2'b00, i_pitch.block[2:1]};
assign rate_scaled = {1'b0, rate_sel} + {3'b000, ksr_factor[3:2]};
assign rate_sat    = rate_scaled[4] ? 4'd15 : rate_scaled[3:0];
assign rate_final  = rate_sat + i_tick.zero_cnt;     // Carry dropped
assign rate_zero   = rate_sel == '0;
assign rate_12     = rate_sat == 4'd12;
assign rate_13     = rate_sat == 4'd13;
assign rate_14     = rate_sat == 4'd14;
assign rate_15     = rate_sat == 4'd15;
assign pre_3       = i_tick.prescaler == 2'd3;

assign intensity = (ksr_factor[1] & ~i_tick.cntr_lo[0])
                 | (ksr_factor[0] & (i_tick.cntr_lo == 2'd0))
                 | ((ksr_factor[1:0] == 2'd3) & (i_tick.cntr_lo == 2'd1));

// Rates below 12 step only on matching counter values
assign slow_atten = (rate_sat < 4'd12) & ~rate_zero
                  & ((rate_final == 4'd12)
                   | ((rate_final == 4'd13) & ksr_factor[1])
                   | ((rate_final == 4'd14) & ksr_factor[0]));

////////////////////////////////////////
// Attenuation delta
assign attn_act = ~quiet & ~start_attack
                & (cur_phase[1] | ((cur_phase == eg_state_pkg::ph_decay) & ~decay_end));

assign sel[0] = slow_atten | (rate_12 & ~intensity);
assign sel[1] = (rate_12 & intensity) | (rate_13 & ~intensity);
assign sel[2] = (rate_13 & intensity) | (rate_14 & ~intensity)
              | (attn_act & ((rate_12 & ~intensity & pre_3)
                           | (rate_12 & intensity & i_tick.prescaler[0])
                           | (rate_13 & ~intensity & i_tick.prescaler[0])
                           | (slow_atten & pre_3)));
assign sel[3] = (rate_14 & intensity) | rate_15;

// Attack steps down by a fraction of the level, sign extended
assign dec_level = (cur_phase == eg_state_pkg::ph_attack) & i_rate.kon & ~rate_15 & ~level_min;
assign inv_level = dec_level ? ~cur_level : '0;

assign delta_0 = sel[0] ? {{4{dec_level}}, inv_level[6:4]} : '0;
assign delta_1 = sel[1] ? {{3{dec_level}}, inv_level[6:3]} : '0;
assign delta_2 = sel[2] ? {{2{dec_level}}, inv_level[6:3], attn_act | inv_level[2]} : '0;
assign delta_3 = sel[3] ? {dec_level, inv_level[6:3], attn_act | inv_level[2], inv_level[1]}
                        : '0;
assign delta   = delta_0 | delta_1 | delta_2 | delta_3;

always_comb begin
    if (quiet & (cur_phase != eg_state_pkg::ph_attack) & ~start_attack) begin
        cur_base = level_max;
    end else if (rate_15 & start_attack) begin
        cur_base = '0;             // Instant attack
    end else begin
        cur_base = cur_level;
    end
end

assign next_level = cur_base + delta;   // Wraps only as a subtraction in attack

////////////////////////////////////////
// Phase transitions
always_comb begin
    if (start_attack) begin
        next_phase = eg_state_pkg::ph_attack;
    end else if (!i_rate.kon) begin
        next_phase = eg_state_pkg::ph_release;
    end else begin
        case (cur_phase)
            eg_state_pkg::ph_attack: begin
                next_phase = level_min ? eg_state_pkg::ph_decay : eg_state_pkg::ph_attack;
            end
            eg_state_pkg::ph_decay: begin
                next_phase = decay_end ? eg_state_pkg::ph_sustain : eg_state_pkg::ph_decay;
            end
            default: next_phase = cur_phase;
        endcase
    end
end

// Head of the storage, doubles as the output
always_ff @(posedge emuclk) begin
    if (!i_RST_n) begin
        o_env_level    <= level_max;
        phase_q        <= eg_state_pkg::ph_release;
        o_pg_phase_rst <= 1'b0;
    end else begin
        o_env_level    <= next_level;
        phase_q        <= next_phase;
        o_pg_phase_rst <= start_attack;
    end
end

// Remaining slots circulate back to the tail
always_ff @(posedge emuclk) begin
    level_sr[0] <= o_env_level;
    phase_sr[0] <= phase_q;
    for (int i = 1; i < sr_len; i++) begin
        level_sr[i] <= level_sr[i-1];
        phase_sr[i] <= phase_sr[i-1];
    end
end

a_no_level_wrap : assert property (@(posedge emuclk) disable iff (!i_RST_n)
    (cur_phase != eg_state_pkg::ph_attack) && !start_attack |=> o_env_level >= $past(cur_level));

endmodule

// File: eg_rate_timer.sv
`include "eg_params.svh"

module eg_rate_timer (
    input  logic                   emuclk,
    input  logic                   i_RST_n,
    input  logic                   i_frame_start,
    output eg_state_pkg::eg_tick_t o_tick
);

localparam int cntr_w  = `EG_COUNTER_W;
localparam int zb_span = 13;              // Counter bits seen by the zero-bit detector

logic [1:0]        prescaler;
logic [cntr_w-1:0] cntr_sr;               // LSB sits at bit 0 in the frame-start cycle
logic              cntr_co;
logic              cntr_cin;
logic [1:0]        cntr_sum;
logic [3:0]        zero_cnt;

////////////////////////////////////////
// Prescaler, one step per frame
always_ff @(posedge emuclk) begin
    if (!i_RST_n) begin
        prescaler <= 2'd0;
    end else if (i_frame_start) begin
        prescaler <= prescaler + 2'd1;
    end
end

////////////////////////////////////////
// Serial counter, one bit per slot cycle

// New chain starts at bit 0 when the next prescaler phase is 3
assign cntr_cin = i_frame_start ? (prescaler == 2'd2) : cntr_co;
assign cntr_sum = {1'b0, cntr_sr[0]} + {1'b0, cntr_cin};

always_ff @(posedge emuclk) begin
    if (!i_RST_n) begin
        cntr_sr <= '0;
        cntr_co <= 1'b0;
    end else begin
        cntr_co <= cntr_sum[1];                        // Carry into the next bit
        cntr_sr <= {cntr_sum[0], cntr_sr[cntr_w-1:1]};
    end
end

// Position of the lowest one bit, zero when none in range
always_comb begin
    zero_cnt = 4'd0;
    for (int i = zb_span - 1; i >= 0; i--) begin
        if (cntr_sr[i]) begin
            zero_cnt = 4'(i + 1);
        end
    end
end

// Frame-start latch, so every slot sees one tick value per frame
always_ff @(posedge emuclk) begin
    if (!i_RST_n) begin
        o_tick <= '0;
    end else if (i_frame_start) begin
        o_tick.prescaler <= prescaler + 2'd1;   // Phase of the frame just begun
        o_tick.zero_cnt  <= zero_cnt;
        o_tick.cntr_lo   <= cntr_sr[1:0];
    end
end

a_prescaler_at_frame : assert property (@(posedge emuclk) disable iff (!i_RST_n)
    !$stable(prescaler) |-> $past(i_frame_start));

endmodule

// File: eg_state_pkg.sv
`include "eg_params.svh"

// Internal envelope state types
package eg_state_pkg;

    typedef enum logic [1:0] {
        ph_attack  = 2'd0,
        ph_decay   = 2'd1,
        ph_sustain = 2'd2,
        ph_release = 2'd3
    } eg_phase_e;

    typedef logic [`EG_LEVEL_W-1:0] eg_level_t;

    // Envelope timing for one frame
    typedef struct packed {
        logic [1:0] prescaler;   // Frame prescaler phase
        logic [3:0] zero_cnt;    // Lowest one bit position of the counter, plus one
        logic [1:0] cntr_lo;     // Counter bits 1:0
    } eg_tick_t;

endpackage

// File: eg_slot_pkg.sv
`include "eg_params.svh"

// Per-operator register fields, presented in the slot's own cycle
package eg_slot_pkg;

    // Pitch of the current slot
    typedef struct packed {
        logic [8:0] fnum;
        logic [2:0] block;
    } eg_pitch_t;

    // Envelope shape and rate control
    typedef struct packed {
        logic                  kon;      // Key on
        logic                  susen;    // Sustain enable
        logic                  etyp;     // Sustained tone
        logic                  carrier;  // Carrier, not modulator
        logic                  ksr;      // Key-scale rate
        logic [`EG_RATE_W-1:0] ar;
        logic [`EG_RATE_W-1:0] dr;
        logic [`EG_RATE_W-1:0] rr;
        logic [`EG_RATE_W-1:0] sl;
    } eg_rate_params_t;

    // Static attenuation terms
    typedef struct packed {
        logic [5:0] tl;
        logic [1:0] ksl;
        logic       am;
    } eg_level_params_t;

endpackage

// File: eg_params.svh
`ifndef EG_PARAMS_SVH
`define EG_PARAMS_SVH

////////////////////////////////////////
// Frame and datapath widths
`define EG_SLOTS            18      // Operator slots per frame
`define EG_LEVEL_W          7       // Attenuation width
`define EG_LEVEL_MAX        127     // Silent
`define EG_RATE_W           4       // AR, DR, RR, SL nibbles
`define EG_COUNTER_W        18      // Serial envelope counter

////////////////////////////////////////
// Fixed rates
`define EG_DAMP_RATE        12      // Key-on over an audible release
`define EG_CARRIER_OFF_RATE 7       // Released carrier, no sustain
`define EG_SUSTAIN_RATE     5       // Release with sustain enabled

// Top level bits all set means quiet
`define EG_QUIET_BITS       5

`endif
